// File: Makefile
# Verilator build and run for the camera pixel path

SIM = obj_dir/Vtb_camera_pipeline

.PHONY: all run clean

all: run

$(SIM): camera_pipeline_top.f $(wildcard *.sv)
	verilator --binary --assert --top-module tb_camera_pipeline \
	  -f camera_pipeline_top.f -o Vtb_camera_pipeline

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bayer_demosaic.sv
// Bayer to RGB demosaic
// Folds each 2x2 Bayer quad into one RGB pixel at half resolution.
// Even rows go into a one-line buffer; odd rows read it back one column
// ahead, so a full quad is on hand at every odd/odd sample
module bayer_demosaic
  import camera_pkg::*;
(
  input  logic   ccd_pixel_clk,
  input  logic   reset,
  input  raw_t   capt_data,
  input  logic   capt_valid,
  input  coord_t capt_x,
  input  coord_t capt_y,
  output raw_t   rgb_red,
  output raw_t   rgb_green,
  output raw_t   rgb_blue,
  output logic   rgb_valid
);

  coord_t           lb_addr;
  logic             lb_wr_en;
  raw_t             lb_rd_data;   // Upper row, current column
  raw_t             lb_rd_prev;   // Upper row, previous column
  raw_t             prev_sample;  // Current row, previous column
  logic [raw_width:0] green_sum;  // One extra bit for the carry
  logic             odd_row;
  logic             emit;

  assign odd_row  = capt_y[0];
  assign lb_wr_en = capt_valid && !odd_row;       // Even rows are stored
  assign emit     = capt_valid && odd_row && capt_x[0];

  // ======================================
  // Line buffer addressing
  // ======================================
  // Odd rows fetch column x+1 during sample x, idle cycles fetch column 0
  always_comb begin
    if (capt_valid && !odd_row) begin
      lb_addr = capt_x;
    end else if (capt_valid) begin
      lb_addr = capt_x + coord_t'(1);  // Read ahead
    end else begin
      lb_addr = '0;  // Primes column 0 for the next line
    end
  end

  bayer_line_buffer u_line_buffer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .addr          (lb_addr),
    .wr_data       (capt_data),
    .wr_en         (lb_wr_en),
    .rd_data       (lb_rd_data)
  );

  // History of the upper row and of the current row
  always_ff @(posedge ccd_pixel_clk) begin
    if (capt_valid) begin
      lb_rd_prev  <= lb_rd_data;
      prev_sample <= capt_data;  // Blue on odd rows
    end
  end

  // Upper-left green plus current green
  assign green_sum = {1'b0, lb_rd_prev} + {1'b0, capt_data};

  // ======================================
  // Pixel output
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (emit) begin
      rgb_red   <= lb_rd_data;              // Upper row, odd column
      rgb_green <= green_sum[raw_width:1];  // Average of the two greens
      rgb_blue  <= prev_sample;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= emit;  // One pixel per quad
    end
  end

endmodule

// File: bayer_line_buffer.sv
// Bayer line buffer
// Single-port memory holding one sensor row of raw samples.
// Write and read share the address, read data one cycle later
module bayer_line_buffer
  import camera_pkg::*;
(
  input  logic   ccd_pixel_clk,
  input  coord_t addr,
  input  raw_t   wr_data,
  input  logic   wr_en,
  output raw_t   rd_data
);

  // ======================================
  // Storage
  // ======================================
  raw_t                       mem [max_line_pixels];
  logic [line_addr_width-1:0] mem_addr;

  assign mem_addr = addr[line_addr_width-1:0];  // Upper index bit unused inside the depth

  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_en) begin
      mem[mem_addr] <= wr_data;
    end
    rd_data <= mem[mem_addr];  // Old data on a same-cycle write
  end

  // Lines wider than the buffer would alias entries.
  // Covers the write index and the read-ahead index from the demosaic
  a_addr_in_range : assert property (@(posedge ccd_pixel_clk)
    !$isunknown(addr) |-> (addr < coord_t'(max_line_pixels)));

endmodule

// File: camera_pipeline_top.f
camera_pkg.sv
bayer_line_buffer.sv
ccd_capture.sv
bayer_demosaic.sv
pixel_packer.sv
frame_rate_meter.sv
camera_pipeline_top.sv
tb_camera_pipeline.sv

// File: camera_pipeline_top.sv
// Camera pixel path top level
// Sensor capture, Bayer demosaic, RGB555 packing and frame rate
// measurement, all on the sensor pixel clock
module camera_pipeline_top
  import camera_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          reset,
  input  raw_t          sensor_data,
  input  logic          frame_valid,
  input  logic          line_valid,
  input  logic          capture_start,
  input  channel_mask_t rgb_mask,
  output rgb555_t       pixel_data,
  output logic          pixel_valid,
  output count_t        frame_count,
  output count_t        frame_rate,
  output logic          rate_pulse
);

  // ======================================
  // Internal streams
  // ======================================
  raw_t   capt_data;   // Capture to demosaic
  logic   capt_valid;
  coord_t capt_x;
  coord_t capt_y;
  logic   frame_done;  // Capture to rate meter
  raw_t   rgb_red;     // Demosaic to packer
  raw_t   rgb_green;
  raw_t   rgb_blue;
  logic   rgb_valid;

  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sensor_data   (sensor_data),
    .frame_valid   (frame_valid),
    .line_valid    (line_valid),
    .capture_start (capture_start),
    .capt_data     (capt_data),
    .capt_valid    (capt_valid),
    .capt_x        (capt_x),
    .capt_y        (capt_y),
    .frame_done    (frame_done),
    .frame_count   (frame_count)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .capt_data     (capt_data),
    .capt_valid    (capt_valid),
    .capt_x        (capt_x),
    .capt_y        (capt_y),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .rgb_valid     (rgb_valid)
  );

  pixel_packer u_packer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .rgb_red       (rgb_red),
    .rgb_green     (rgb_green),
    .rgb_blue      (rgb_blue),
    .rgb_valid     (rgb_valid),
    .rgb_mask      (rgb_mask),
    .pixel_data    (pixel_data),
    .pixel_valid   (pixel_valid)
  );

  frame_rate_meter u_rate_meter (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .frame_done    (frame_done),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

endmodule

// File: camera_pkg.sv
// Camera pixel path shared definitions
// Sample, coordinate, count and pixel widths, the line buffer depth,
// the frame rate window and the capture FSM states
package camera_pkg;

  // ======================================
  // Widths
  // ======================================
  localparam int raw_width       = 12;                      // Sensor ADC bits
  localparam int coord_width     = 12;                      // Column / row index
  localparam int count_width     = 32;                      // Frame counters
  localparam int rgb_field_width = 5;                       // Kept bits per channel
  localparam int pixel_width     = 1 + 3 * rgb_field_width; // Zero bit plus RGB fields

  // Channel enable bits
  localparam int mask_width     = 3;
  localparam int mask_red_bit   = 2;
  localparam int mask_green_bit = 1;
  localparam int mask_blue_bit  = 0;

  // ======================================
  // Depths and windows
  // ======================================
  localparam int max_line_pixels    = 2048;  // Line buffer entries
  localparam int line_addr_width    = $clog2(max_line_pixels);
  localparam int rate_window_cycles = 4096;  // Pixel clocks per rate window
  localparam int rate_window_width  = $clog2(rate_window_cycles);

  // ======================================
  // Types
  // ======================================
  // One raw Bayer sample, also one demosaiced component
  typedef logic [raw_width-1:0] raw_t;

  typedef logic [coord_width-1:0] coord_t;  // Column or row index

  // Frame count or frame rate
  typedef logic [count_width-1:0] count_t;

  // Bit 15 zero, then red, green, blue fields
  typedef logic [pixel_width-1:0] rgb555_t;

  typedef logic [mask_width-1:0] channel_mask_t;  // Red, green, blue enables

  // Position inside the rate window
  typedef logic [rate_window_width-1:0] window_t;

  // Capture FSM
  typedef enum logic [1:0] {
    cap_idle,        // Waiting for the start switch
    cap_wait_frame,  // Armed, waiting for a frame start
    cap_active       // Frame being captured
  } capture_state_t;

endpackage

// File: ccd_capture.sv
// Sensor capture front end
// Registers the raw sample and its frame / line strobes, runs the
// start/stop FSM and produces the capture stream with column and row
// indices, plus a frame done pulse and a running frame count
module ccd_capture
  import camera_pkg::*;
(
  input  logic   ccd_pixel_clk,
  input  logic   reset,
  input  raw_t   sensor_data,
  input  logic   frame_valid,
  input  logic   line_valid,
  input  logic   capture_start,
  output raw_t   capt_data,
  output logic   capt_valid,
  output coord_t capt_x,
  output coord_t capt_y,
  output logic   frame_done,
  output count_t frame_count
);

  raw_t           data_r;          // Registered pin data
  logic           fval_r, lval_r;  // Registered strobes
  logic           fval_d, lval_d;  // One cycle older, for edges
  logic           fval_rise, fval_fall, lval_fall;
  logic           frame_start;
  logic           sample;
  capture_state_t state;
  coord_t         col_cnt, row_cnt;
  coord_t         col_now, row_now;

  // ======================================
  // Input register stage
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_r <= sensor_data;
    if (reset) begin
      fval_r <= 1'b0;
      lval_r <= 1'b0;
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_r <= frame_valid;
      lval_r <= line_valid;
      fval_d <= fval_r;
      lval_d <= lval_r;
    end
  end

  assign fval_rise = fval_r & ~fval_d;
  assign fval_fall = ~fval_r & fval_d;
  assign lval_fall = ~lval_r & lval_d;

  // First cycle of a captured frame, state still cap_wait_frame
  assign frame_start = (state == cap_wait_frame) && fval_rise;
  assign sample      = fval_r && lval_r && ((state == cap_active) || frame_start);

  // Counters restart on the frame's first cycle
  assign col_now = frame_start ? '0 : col_cnt;
  assign row_now = frame_start ? '0 : row_cnt;

  // ======================================
  // Capture FSM
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      state <= cap_idle;
    end else begin
      case (state)
        cap_idle:       if (capture_start) state <= cap_wait_frame;
        cap_wait_frame: if (fval_rise) state <= cap_active;
        cap_active: begin
          if (fval_fall) begin  // Frame over, re-arm only if still enabled
            state <= capture_start ? cap_wait_frame : cap_idle;
          end
        end
        default:        state <= cap_idle;
      endcase
    end
  end

  // Column, row and stream registers
  always_ff @(posedge ccd_pixel_clk) begin
    if (sample) begin
      capt_data <= data_r;
    end
    if (reset) begin
      col_cnt    <= '0;
      row_cnt    <= '0;
      capt_x     <= '0;
      capt_y     <= '0;
      capt_valid <= 1'b0;
    end else begin
      capt_valid <= sample;
      if (sample) begin
        capt_x  <= col_now;
        capt_y  <= row_now;
        col_cnt <= col_now + coord_t'(1);
      end else if (lval_fall || frame_start) begin
        col_cnt <= '0;  // New line
      end
      if (frame_start) begin
        row_cnt <= '0;
      end else if ((state == cap_active) && lval_fall) begin
        row_cnt <= row_cnt + coord_t'(1);
      end
    end
  end

  // Frame done pulse and frame counter
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      frame_done  <= 1'b0;
      frame_count <= '0;
    end else begin
      frame_done <= (state == cap_active) && fval_fall;
      if (frame_done) frame_count <= frame_count + count_t'(1);  // One cycle after the pulse
    end
  end

  // Stream only flows while a frame is being captured
  a_valid_in_frame : assert property (@(posedge ccd_pixel_clk) disable iff (reset)
    capt_valid |-> (state == cap_active));

endmodule

// File: frame_rate_meter.sv
// Frame rate meter
// Counts frame done pulses over a fixed window of pixel clocks,
// publishes the count at each window wrap and toggles a pulse output
module frame_rate_meter
  import camera_pkg::*;
(
  input  logic   ccd_pixel_clk,
  input  logic   reset,
  input  logic   frame_done,
  output count_t frame_rate,
  output logic   rate_pulse
);

  window_t window_cnt;  // Pixel clocks into the window
  count_t  frame_acc;   // Frames seen so far in the window
  logic    window_wrap;

  assign window_wrap = (window_cnt == window_t'(rate_window_cycles - 1));

  // ======================================
  // Window timer
  // ======================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      window_cnt <= '0;
      rate_pulse <= 1'b0;
    end else if (window_wrap) begin
      window_cnt <= '0;
      rate_pulse <= ~rate_pulse;  // One edge per window
    end else begin
      window_cnt <= window_cnt + window_t'(1);
    end
  end

  // Frame accumulation, last cycle's pulse still counts
  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      frame_acc  <= '0;
      frame_rate <= '0;
    end else if (window_wrap) begin
      frame_rate <= frame_acc + count_t'(frame_done);
      frame_acc  <= '0;
    end else begin
      frame_acc <= frame_acc + count_t'(frame_done);
    end
  end

endmodule

// File: pixel_packer.sv
// RGB555 pixel packer
// Keeps the top bits of each channel, zeroes disabled channels and
// registers the 16-bit word with a leading zero bit
module pixel_packer
  import camera_pkg::*;
(
  input  logic          ccd_pixel_clk,
  input  logic          reset,
  input  raw_t          rgb_red,
  input  raw_t          rgb_green,
  input  raw_t          rgb_blue,
  input  logic          rgb_valid,
  input  channel_mask_t rgb_mask,
  output rgb555_t       pixel_data,
  output logic          pixel_valid
);

  logic [rgb_field_width-1:0] red_field;
  logic [rgb_field_width-1:0] green_field;
  logic [rgb_field_width-1:0] blue_field;

  // ======================================
  // Truncate and mask
  // ======================================
  assign red_field   = rgb_mask[mask_red_bit]
                       ? rgb_red[raw_width-1 -: rgb_field_width] : '0;
  assign green_field = rgb_mask[mask_green_bit]
                       ? rgb_green[raw_width-1 -: rgb_field_width] : '0;
  assign blue_field  = rgb_mask[mask_blue_bit]
                       ? rgb_blue[raw_width-1 -: rgb_field_width] : '0;

  // Output word
  always_ff @(posedge ccd_pixel_clk) begin
    if (rgb_valid) begin
      pixel_data <= {1'b0, red_field, green_field, blue_field};  // MSB always zero
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (reset) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= rgb_valid;
    end
  end

endmodule

// File: tb_camera_pipeline.sv
// Camera pixel path testbench
// Drives Bayer frames into the pipeline top level, predicts the RGB555
// words from the quad and packing rules and checks them in order,
// together with latency, frame count and frame rate
module tb_camera_pipeline
  import camera_pkg::*;
();

  logic          ccd_pixel_clk = 1'b0;
  logic          reset;
  raw_t          sensor_data;
  logic          frame_valid, line_valid, capture_start;
  channel_mask_t rgb_mask;
  rgb555_t       pixel_data;
  logic          pixel_valid, rate_pulse;
  count_t        frame_count, frame_rate;

  rgb555_t     expect_q[$];       // Predicted words in order
  int          drive_q[$];        // Cycle each odd/odd sample was driven
  int          done_q[$];         // Cycle each captured frame reaches the counters
  logic [31:0] rand_state = 32'had89;
  int          cycle = 0;
  int          err_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          rx_count = 0;      // Words seen at the output
  int          last_latency = 0;
  int          toggle_count = 0;  // Rate windows seen
  int          last_toggle = 0;
  bit          have_toggle = 1'b0;
  bit          checking = 1'b0;
  logic        last_pulse = 1'b0;
  int          frames_done = 0;   // Captured frames already due at the counters
  int          rate_snap = 0;     // Frames due at the previous window end
  rgb555_t     exp_word;
  int          drive_cycle;

  camera_pipeline_top dut (
    .ccd_pixel_clk (ccd_pixel_clk),
    .reset         (reset),
    .sensor_data   (sensor_data),
    .frame_valid   (frame_valid),
    .line_valid    (line_valid),
    .capture_start (capture_start),
    .rgb_mask      (rgb_mask),
    .pixel_data    (pixel_data),
    .pixel_valid   (pixel_valid),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_pulse    (rate_pulse)
  );

  always #4 ccd_pixel_clk = ~ccd_pixel_clk;  // Period 8
  always @(posedge ccd_pixel_clk) cycle <= cycle + 1;

  // ========================================
  // Reference model
  // ========================================
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Top 5 bits per channel with masked channels and the MSB at zero
  function automatic rgb555_t expected_word(input raw_t r, input raw_t g, input raw_t b,
                                            input channel_mask_t m);
    logic [4:0] rf, gf, bf;
    rf = m[2] ? r[11:7] : 5'd0;
    gf = m[1] ? g[11:7] : 5'd0;
    bf = m[0] ? b[11:7] : 5'd0;
    return {1'b0, rf, gf, bf};
  endfunction

  // One sensor frame with a predicted word per odd/odd sample when captured
  task automatic send_frame(input int width, input int height, input int line_gap,
                            input int frame_gap, input bit captured);
    raw_t        upper [max_line_pixels];  // Last even row
    raw_t        cur [max_line_pixels];
    logic [12:0] gsum;
    @(negedge ccd_pixel_clk);
    frame_valid = 1'b1;
    for (int y = 0; y < height; y++) begin
      for (int x = 0; x < width; x++) begin
        @(negedge ccd_pixel_clk);
        rand_state  = lcg_next(rand_state);
        sensor_data = rand_state[27:16];
        line_valid  = 1'b1;
        cur[x]      = rand_state[27:16];
        if (captured && (y % 2 == 1) && (x % 2 == 1)) begin
          gsum = {1'b0, upper[x-1]} + {1'b0, cur[x]};  // Two greens averaged
          expect_q.push_back(expected_word(upper[x], gsum[12:1], cur[x-1], rgb_mask));
          drive_q.push_back(cycle);
        end
      end
      if (y % 2 == 0) upper = cur;
      for (int g = 0; g < line_gap; g++) begin
        @(negedge ccd_pixel_clk);
        line_valid = 1'b0;
      end
    end
    frame_valid = 1'b0;
    if (captured) done_q.push_back(cycle + 3);  // Pulse two cycles on, counters one more
    repeat (frame_gap) @(negedge ccd_pixel_clk);
  endtask

  // ========================================
  // Output monitor
  // ========================================
  always @(negedge ccd_pixel_clk) begin
    if (checking) begin
      while (done_q.size() != 0 && done_q[0] <= cycle) begin
        void'(done_q.pop_front());
        frames_done++;
      end
      if (pixel_valid) begin
        rx_count++;
        if (pixel_data[pixel_width-1] !== 1'b0) begin
          $display("error pixel_data[15]: got %h expected 0", pixel_data[pixel_width-1]);
          err_count++;
        end
        if (expect_q.size() == 0) begin
          $display("pixel word %h arrived while none was expected", pixel_data);
          err_count++;
        end else begin
          exp_word     = expect_q.pop_front();
          drive_cycle  = drive_q.pop_front();
          last_latency = cycle - drive_cycle;
          if (pixel_data !== exp_word) begin
            $display("error pixel_data: got %h expected %h", pixel_data, exp_word);
            err_count++;
          end
          if (last_latency != 4) begin
            $display("pixel word came %0d cycles after its sample, not 4", last_latency);
            err_count++;
          end
        end
      end
      if (rate_pulse !== last_pulse) begin  // Window just ended
        toggle_count++;
        if (frame_rate !== count_t'(frames_done - rate_snap)) begin
          $display("error frame_rate: got %h expected %h", frame_rate,
                   count_t'(frames_done - rate_snap));
          err_count++;
        end
        if (have_toggle && (cycle - last_toggle != rate_window_cycles)) begin
          $display("rate_pulse toggled after %0d cycles instead of a full window",
                   cycle - last_toggle);
          err_count++;
        end
        have_toggle = 1'b1;
        last_toggle = cycle;
        rate_snap   = frames_done;
        last_pulse  = rate_pulse;
      end
    end
  end

  // ========================================
  // Helpers
  // ========================================
  task automatic drain_pixels();
    int t;
    for (t = 0; t < 400 && expect_q.size() != 0; t++) @(negedge ccd_pixel_clk);
    if (expect_q.size() != 0) begin
      $display("timeout with %0d predicted pixel words never seen", expect_q.size());
      err_count++;
      expect_q.delete();
      drive_q.delete();
    end
    repeat (8) @(negedge ccd_pixel_clk);  // Room for stray extra words
  endtask

  task automatic wait_frame_count(input count_t target);
    int t;
    for (t = 0; t < 200 && frame_count != target; t++) @(negedge ccd_pixel_clk);
    if (frame_count != target) begin
      $display("error frame_count: got %h expected %h", frame_count, target);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (err_count == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               err_count - err_before);
    end
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic reset_and_idle();
    int e;
    e = err_count;
    if (pixel_valid !== 1'b0) begin
      $display("error pixel_valid: got %h expected %h", pixel_valid, 1'b0);
      err_count++;
    end
    if (rate_pulse !== 1'b0) begin
      $display("error rate_pulse: got %h expected %h", rate_pulse, 1'b0);
      err_count++;
    end
    if (frame_count !== '0) begin
      $display("error frame_count: got %h expected %h", frame_count, count_t'(0));
      err_count++;
    end
    send_frame(8, 4, 2, 6, 1'b0);  // Start switch off
    wait_frame_count('0);
    drain_pixels();
    report_test("reset and idle", e);
  endtask

  task automatic full_frame();
    int e, rx0;
    e   = err_count;
    rx0 = rx_count;
    rgb_mask      = 3'b111;
    capture_start = 1'b1;
    repeat (3) @(negedge ccd_pixel_clk);
    send_frame(8, 4, 2, 6, 1'b1);
    drain_pixels();
    if (rx_count - rx0 != 8) begin
      $display("frame gave %0d pixel words instead of 8", rx_count - rx0);
      err_count++;
    end
    report_test("random 8x4 frame", e);
  endtask

  task automatic channel_masks();
    int e;
    e = err_count;
    for (int i = 0; i < 3; i++) begin
      rgb_mask = channel_mask_t'(3'b100 >> i);  // Red, green, blue alone
      send_frame(8, 4, 2, 6, 1'b1);
      drain_pixels();
    end
    rgb_mask = 3'b111;
    report_test("channel masks", e);
  endtask

  task automatic frame_counting();
    int     e;
    count_t base;
    e    = err_count;
    base = count_t'(frames_done);
    for (int i = 0; i < 3; i++) send_frame(8, 4, 2, 6, 1'b1);
    wait_frame_count(base + 3);
    fork
      send_frame(8, 4, 2, 6, 1'b1);  // Finishes despite the switch
      begin
        repeat (10) @(negedge ccd_pixel_clk);
        capture_start = 1'b0;
      end
    join
    send_frame(8, 4, 2, 6, 1'b0);  // Not captured
    wait_frame_count(base + 4);
    drain_pixels();
    report_test("frame count and stop", e);
  endtask

  task automatic rate_windows();
    int e, t0, n;
    e  = err_count;
    t0 = toggle_count;
    capture_start = 1'b1;
    for (n = 0; n < 1000 && toggle_count < t0 + 2; n++) send_frame(4, 2, 1, 4, 1'b1);
    if (toggle_count < t0 + 2) begin
      $display("timeout waiting for two rate windows");
      err_count++;
    end
    if (frame_rate == '0) begin
      $display("frame_rate stayed zero while frames were captured");
      err_count++;
    end
    drain_pixels();
    report_test("frame rate window", e);
  endtask

  task automatic pixel_latency();
    int e, rx0;
    e   = err_count;
    rx0 = rx_count;
    send_frame(4, 2, 2, 6, 1'b1);
    drain_pixels();
    if (rx_count - rx0 != 2 || last_latency != 4) begin
      $display("latency frame gave %0d words, last after %0d cycles",
               rx_count - rx0, last_latency);
      err_count++;
    end
    report_test("pin to word latency", e);
  endtask

  initial begin
    reset         = 1'b1;
    sensor_data   = '0;
    frame_valid   = 1'b0;
    line_valid    = 1'b0;
    capture_start = 1'b0;
    rgb_mask      = 3'b111;
    repeat (8) @(posedge ccd_pixel_clk);
    @(negedge ccd_pixel_clk);
    reset    = 1'b0;
    checking = 1'b1;
    reset_and_idle();
    full_frame();
    channel_masks();
    frame_counting();
    rate_windows();
    pixel_latency();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
